// ==== bp_pkg.sv ====
// Shared definitions for the 15-bay drive backplane controller.
// Register offsets are byte addresses on a 32-bit APB bus with an 8-bit paddr.
// Drive masks are active high, bit i belongs to bay i+1.
// Only the low N_DRIVES (or 2*N_DRIVES) bits of a register are implemented.

`default_nettype none

package bp_pkg;

	//******************************************************************
	// Sizes and basic vectors
	//******************************************************************
	localparam int N_DRIVES = 15;

	typedef logic [N_DRIVES-1:0] drive_mask_t;

	// Normalized status, 1 means present or good
	typedef struct packed {
		drive_mask_t insert;
		drive_mask_t p5v_good;
		drive_mask_t p12v_good;
	} drive_status_t;

	//******************************************************************
	// LED control
	//******************************************************************
	typedef enum logic [1:0] {
		LED_OFF  = 2'd0,
		LED_ON   = 2'd1,
		LED_SLOW = 2'd2,
		LED_FAST = 2'd3
	} led_mode_e;

	// Entry i sits at bits 2i+1..2i
	typedef led_mode_e [N_DRIVES-1:0] led_mode_vec_t;

	typedef struct packed {
		led_mode_vec_t health;
		led_mode_vec_t fault;
	} led_cfg_t;

	typedef struct packed {
		logic slow;
		logic fast;
	} blink_t;

	//******************************************************************
	// APB slave port
	//******************************************************************
	typedef struct packed {
		logic [7:0]  paddr;
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Register map
	localparam logic [7:0] REG_INSERT      = 8'h00;
	localparam logic [7:0] REG_P5V_GOOD    = 8'h04;
	localparam logic [7:0] REG_P12V_GOOD   = 8'h08;
	localparam logic [7:0] REG_PWR_EN      = 8'h0C;
	localparam logic [7:0] REG_HEALTH_MODE = 8'h10;
	localparam logic [7:0] REG_FAULT_MODE  = 8'h14;
	localparam logic [7:0] REG_ID          = 8'h3C;

	// Identification word, device ID on top and firmware version in the low byte
	localparam logic [15:0] DEVICE_ID  = 16'hB415;
	localparam logic [7:0]  FW_VERSION = 8'h01;
	localparam logic [31:0] ID_WORD    = {DEVICE_ID, 8'h00, FW_VERSION};

endpackage

`default_nettype wire

// ==== drive_status_sync.sv ====
// Two-flop synchronizer for the drive status pins.
// insert_l is active low on the board and is inverted before the first stage.
// Output follows a pin change after two SYSCLK edges.

`timescale 1ns/1ps
`default_nettype none

module drive_status_sync (
	input  logic                  SYSCLK,
	input  logic                  RESET_N,
	input  bp_pkg::drive_mask_t   insert_l,
	input  bp_pkg::drive_mask_t   p5v_good,
	input  bp_pkg::drive_mask_t   p12v_good,
	output bp_pkg::drive_status_t status
);

	import bp_pkg::*;

	drive_status_t pin_norm;
	drive_status_t meta_q;
	drive_status_t sync_q;

	// Every field reads 1 for present or good
	assign pin_norm.insert    = ~insert_l;
	assign pin_norm.p5v_good  = p5v_good;
	assign pin_norm.p12v_good = p12v_good;

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			meta_q <= '0;
			sync_q <= '0;
		end
		else
		begin
			meta_q <= pin_norm;
			sync_q <= meta_q;
		end
	end

	assign status = sync_q;

endmodule

`default_nettype wire

// ==== blink_timebase.sv ====
// Blink timebase, one tick every CLKS_PER_TICK SYSCLK cycles.
// fast toggles every tick, slow every 4 ticks, heartbeat every 8 ticks.
// All phases start low out of reset.

`timescale 1ns/1ps
`default_nettype none

module blink_timebase #(
	parameter int CLKS_PER_TICK = 50_000_000
) (
	input  logic           SYSCLK,
	input  logic           RESET_N,
	output bp_pkg::blink_t blink,
	output logic           heartbeat
);

	import bp_pkg::*;

	localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

	logic [CNT_W-1:0] cyc_cnt;
	logic [2:0]       tick_cnt;
	logic             tick;
	logic             hb_q;

	assign tick = (cyc_cnt == CNT_W'(CLKS_PER_TICK - 1));

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			cyc_cnt <= '0;
			tick_cnt <= '0;
			hb_q <= 1'b0;
		end
		else if (tick)
		begin
			cyc_cnt <= '0;
			tick_cnt <= tick_cnt + 3'd1;
			// Counter wrap marks 8 ticks
			if (tick_cnt == 3'd7)
				hb_q <= ~hb_q;
		end
		else
			cyc_cnt <= cyc_cnt + 1'b1;
	end

	assign blink.fast = tick_cnt[0];
	assign blink.slow = tick_cnt[2];
	assign heartbeat  = hb_q;

	a_cyc_in_range: assert property (
		@(posedge SYSCLK) disable iff (!RESET_N)
		int'(cyc_cnt) < CLKS_PER_TICK
	);

endmodule

`default_nettype wire

// ==== drive_led_driver.sv ====
// Per-drive health and fault LED outputs, active high.
// Mode changes show one SYSCLK after the register write.
// Blinking modes follow the shared phases, so all bays blink in step.

`timescale 1ns/1ps
`default_nettype none

module drive_led_driver (
	input  logic                SYSCLK,
	input  logic                RESET_N,
	input  bp_pkg::led_cfg_t    led_cfg,
	input  bp_pkg::blink_t      blink,
	output bp_pkg::drive_mask_t health_led,
	output bp_pkg::drive_mask_t fault_led
);

	import bp_pkg::*;

	drive_mask_t health_nxt;
	drive_mask_t fault_nxt;

	// LED level for one mode at the current blink phase
	function automatic logic led_level(led_mode_e mode, blink_t phase);
		case (mode)
			LED_OFF:  return 1'b0;
			LED_ON:   return 1'b1;
			LED_SLOW: return phase.slow;
			default:  return phase.fast;
		endcase
	endfunction

	always_comb
	begin
		for (int i = 0; i < N_DRIVES; i++)
		begin
			health_nxt[i] = led_level(led_cfg.health[i], blink);
			fault_nxt[i] = led_level(led_cfg.fault[i], blink);
		end
	end

	//******************************************************************
	// Output registers
	//******************************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			health_led <= '0;
			fault_led <= '0;
		end
		else
		begin
			health_led <= health_nxt;
			fault_led <= fault_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== bp_reg_ctrl.sv ====
// APB register file for the drive backplane.
// Zero wait states, pready is tied high.
// Unmapped offsets and writes to read-only registers raise pslverr and change nothing.
// prdata is zero outside a read access cycle.

`timescale 1ns/1ps
`default_nettype none

module bp_reg_ctrl (
	input  logic                  SYSCLK,
	input  logic                  RESET_N,
	input  bp_pkg::apb_req_t      apb_req,
	output bp_pkg::apb_rsp_t      apb_rsp,
	input  bp_pkg::drive_status_t status,
	output bp_pkg::drive_mask_t   pwr_en_l,
	output bp_pkg::led_cfg_t      led_cfg
);

	import bp_pkg::*;

	drive_mask_t pwr_en_q;
	led_cfg_t    led_cfg_q;

	logic        access;
	logic        addr_hit;
	logic        read_only;
	logic        slv_err;
	logic        wr_ok;
	logic        wr_pwr;
	logic        wr_health;
	logic        wr_fault;
	logic [31:0] rd_word;

	//******************************************************************
	// Address decode and read mux
	//******************************************************************
	assign access = apb_req.psel & apb_req.penable;

	always_comb
	begin
		rd_word = '0;
		addr_hit = 1'b1;
		read_only = 1'b0;
		case (apb_req.paddr)
			REG_INSERT:
			begin
				rd_word = 32'(status.insert);
				read_only = 1'b1;
			end
			REG_P5V_GOOD:
			begin
				rd_word = 32'(status.p5v_good);
				read_only = 1'b1;
			end
			REG_P12V_GOOD:
			begin
				rd_word = 32'(status.p12v_good);
				read_only = 1'b1;
			end
			REG_PWR_EN:      rd_word = 32'(pwr_en_q);
			REG_HEALTH_MODE: rd_word = 32'(led_cfg_q.health);
			REG_FAULT_MODE:  rd_word = 32'(led_cfg_q.fault);
			REG_ID:
			begin
				rd_word = ID_WORD;
				read_only = 1'b1;
			end
			default:         addr_hit = 1'b0;
		endcase
	end

	assign slv_err = access & (~addr_hit | (apb_req.pwrite & read_only));

	// Data only on a clean read
	assign apb_rsp.prdata  = (access & ~apb_req.pwrite & ~slv_err) ? rd_word : '0;
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = slv_err;

	// Write strobes
	assign wr_ok     = access & apb_req.pwrite & ~slv_err;
	assign wr_pwr    = wr_ok & (apb_req.paddr == REG_PWR_EN);
	assign wr_health = wr_ok & (apb_req.paddr == REG_HEALTH_MODE);
	assign wr_fault  = wr_ok & (apb_req.paddr == REG_FAULT_MODE);

	//******************************************************************
	// Control registers
	//******************************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			pwr_en_q <= '0;
			led_cfg_q <= '0;
		end
		else
		begin
			if (wr_pwr)
				pwr_en_q <= apb_req.pwdata[N_DRIVES-1:0];
			if (wr_health)
				led_cfg_q.health <= led_mode_vec_t'(apb_req.pwdata[2*N_DRIVES-1:0]);
			if (wr_fault)
				led_cfg_q.fault <= led_mode_vec_t'(apb_req.pwdata[2*N_DRIVES-1:0]);
		end
	end

	// Power pins are active low, drives start unpowered
	assign pwr_en_l = ~pwr_en_q;
	assign led_cfg  = led_cfg_q;

	//******************************************************************
	// Host protocol and config checks
	//******************************************************************
	a_penable_with_psel: assert property (
		@(posedge SYSCLK) disable iff (!RESET_N)
		apb_req.penable |-> apb_req.psel
	);

	// Setup cycle holds address and direction into the access cycle
	a_setup_stable: assert property (
		@(posedge SYSCLK) disable iff (!RESET_N)
		(apb_req.psel & ~apb_req.penable) |=>
			($stable(apb_req.paddr) & $stable(apb_req.pwrite))
	);

	a_mode_encoding: assert property (
		@(posedge SYSCLK) disable iff (!RESET_N)
		!$isunknown(led_cfg_q)
	);

endmodule

`default_nettype wire

// ==== bp_top.sv ====
// Drive backplane controller top level.
// Host access is an APB slave port with zero wait states.
// CLKS_PER_TICK sets the blink tick; the default is 1 s at a 50 MHz SYSCLK.
// Raw pins are asynchronous and pass a two-flop synchronizer.

`timescale 1ns/1ps
`default_nettype none

module bp_top #(
	parameter int CLKS_PER_TICK = 50_000_000
) (
	input  logic                SYSCLK,
	input  logic                RESET_N,
	input  bp_pkg::apb_req_t    apb_req,
	output bp_pkg::apb_rsp_t    apb_rsp,
	input  bp_pkg::drive_mask_t insert_l,
	input  bp_pkg::drive_mask_t p5v_good,
	input  bp_pkg::drive_mask_t p12v_good,
	output bp_pkg::drive_mask_t pwr_en_l,
	output bp_pkg::drive_mask_t health_led,
	output bp_pkg::drive_mask_t fault_led,
	output logic                heartbeat
);

	import bp_pkg::*;

	drive_status_t status;
	led_cfg_t      led_cfg;
	blink_t        blink;

	//******************************************************************
	// Drive status pins
	//******************************************************************
	drive_status_sync i_status_sync (
		.SYSCLK    (SYSCLK),
		.RESET_N   (RESET_N),
		.insert_l  (insert_l),
		.p5v_good  (p5v_good),
		.p12v_good (p12v_good),
		.status    (status)
	);

	//******************************************************************
	// Host register file
	//******************************************************************
	bp_reg_ctrl i_reg_ctrl (
		.SYSCLK   (SYSCLK),
		.RESET_N  (RESET_N),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.status   (status),
		.pwr_en_l (pwr_en_l),
		.led_cfg  (led_cfg)
	);

	//******************************************************************
	// Blink phases and LED outputs
	//******************************************************************
	blink_timebase #(
		.CLKS_PER_TICK (CLKS_PER_TICK)
	) i_timebase (
		.SYSCLK    (SYSCLK),
		.RESET_N   (RESET_N),
		.blink     (blink),
		.heartbeat (heartbeat)
	);

	drive_led_driver i_led_driver (
		.SYSCLK     (SYSCLK),
		.RESET_N    (RESET_N),
		.led_cfg    (led_cfg),
		.blink      (blink),
		.health_led (health_led),
		.fault_led  (fault_led)
	);

endmodule

`default_nettype wire

// ==== tb_bp_top.sv ====
// Testbench for bp_top, driven line by line from bp_trace.txt.
// Run from the project root so the trace path resolves.
// CLKS_PER_TICK is 4, so a 32-tick blink window lasts 128 cycles.

`timescale 1ns/1ps
`default_nettype none

module tb_bp_top;

	import bp_pkg::*;

	localparam int TICK_CLKS    = 4;
	localparam int WINDOW_TICKS = 32;
	localparam int MARGIN       = 40;

	logic        SYSCLK;
	logic        RESET_N;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	drive_mask_t insert_l;
	drive_mask_t p5v_good;
	drive_mask_t p12v_good;
	drive_mask_t pwr_en_l;
	drive_mask_t health_led;
	drive_mask_t fault_led;
	logic        heartbeat;

	string trace_lines[$];
	int    trace_line_no[$];
	int    cycle_cnt    = 0;
	int    cycle_limit  = 0;
	int    rsp_errors   = 0;
	int    mask_errors  = 0;
	int    blink_errors = 0;
	int    other_errors = 0;

	bp_top #(
		.CLKS_PER_TICK (TICK_CLKS)
	) i_dut (
		.SYSCLK     (SYSCLK),
		.RESET_N    (RESET_N),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.insert_l   (insert_l),
		.p5v_good   (p5v_good),
		.p12v_good  (p12v_good),
		.pwr_en_l   (pwr_en_l),
		.health_led (health_led),
		.fault_led  (fault_led),
		.heartbeat  (heartbeat)
	);

	initial
	begin
		SYSCLK = 1'b0;
		forever #20 SYSCLK = ~SYSCLK;
	end

	always @(posedge SYSCLK)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
		begin
			$display("timeout: the trace did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//**********************************************************************
	// Compare tasks
	//**********************************************************************
	task automatic check_rsp(input string name, input apb_rsp_t expected, input apb_rsp_t actual);
		if (actual !== expected)
		begin
			rsp_errors++;
			$display("mismatch %s: expected prdata %08h pready %0b pslverr %0b, actual %08h %0b %0b",
				name, expected.prdata, expected.pready, expected.pslverr,
				actual.prdata, actual.pready, actual.pslverr);
		end
	endtask

	task automatic check_mask(input string name, input drive_mask_t expected,
		input drive_mask_t actual);
		if (actual !== expected)
		begin
			mask_errors++;
			$display("mismatch %s: expected %04h actual %04h", name, expected, actual);
		end
	endtask

	task automatic check_blink(input string name, input int expected, input int actual);
		if (actual < expected - 1 || actual > expected + 1)
		begin
			blink_errors++;
			$display("mismatch %s: expected %0d +/-1 toggles actual %0d", name, expected, actual);
		end
	endtask

	//**********************************************************************
	// APB host and LED sampling
	//**********************************************************************
	task automatic apb_xfer(input logic [7:0] addr, input logic is_write,
		input logic [31:0] wdata, output apb_rsp_t rsp);
		int gap;
		gap = int'($urandom_range(3, 0));
		repeat (gap) @(posedge SYSCLK);
		@(posedge SYSCLK);
		apb_req.paddr <= addr;
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= is_write;
		apb_req.pwdata <= wdata;
		@(posedge SYSCLK);
		apb_req.penable <= 1'b1;
		@(negedge SYSCLK);
		while (apb_rsp.pready !== 1'b1)
		begin
			@(posedge SYSCLK);
			@(negedge SYSCLK);
		end
		rsp = apb_rsp;
		@(posedge SYSCLK);
		apb_req <= '0;
	endtask

	// led 0 is health, 1 is fault, 2 is heartbeat
	function automatic logic led_bit(input int drive, input int led);
		case (led)
			0:       return health_led[drive-1];
			1:       return fault_led[drive-1];
			default: return heartbeat;
		endcase
	endfunction

	function automatic int expected_toggles(input int led, input int mode);
		if (led == 2)
			return WINDOW_TICKS / 8;
		if (mode == int'(LED_FAST))
			return WINDOW_TICKS;
		if (mode == int'(LED_SLOW))
			return WINDOW_TICKS / 4;
		return 0;
	endfunction

	task automatic blink_window(input string name, input int drive, input int led,
		input int mode);
		logic prev;
		logic cur;
		int   toggles;
		toggles = 0;
		if (led < 2 && (drive < 1 || drive > N_DRIVES))
		begin
			other_errors++;
			$display("%s: drive number %0d is outside 1 to %0d", name, drive, N_DRIVES);
			return;
		end
		// Let a mode write reach the LED register
		repeat (2) @(posedge SYSCLK);
		@(negedge SYSCLK);
		prev = led_bit(drive, led);
		repeat (WINDOW_TICKS * TICK_CLKS)
		begin
			@(negedge SYSCLK);
			cur = led_bit(drive, led);
			if (cur !== prev)
				toggles++;
			prev = cur;
		end
		check_blink(name, expected_toggles(led, mode), toggles);
	endtask

	//**********************************************************************
	// Trace handling
	//**********************************************************************
	function automatic int line_budget(input byte op);
		case (op)
			"P":      return 6;
			"W", "R": return 7;
			"C":      return 2;
			"L":      return 4;
			"B":      return WINDOW_TICKS * TICK_CLKS + 4;
			default:  return 1;
		endcase
	endfunction

	task automatic run_line(input string line, input int line_no);
		byte         op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		int          n;
		apb_rsp_t    rsp;
		apb_rsp_t    expected;
		op = line.getc(0);
		a = '0;
		b = '0;
		c = '0;
		n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
		expected.pready = 1'b1;
		expected.pslverr = c[0];
		case (op)
			"P":
			begin
				@(posedge SYSCLK);
				insert_l <= drive_mask_t'(a);
				p5v_good <= drive_mask_t'(b);
				p12v_good <= drive_mask_t'(c);
				repeat (4) @(posedge SYSCLK);
			end
			"W":
			begin
				apb_xfer(a[7:0], 1'b1, b, rsp);
				expected.prdata = '0;
				check_rsp($sformatf("write %02h (line %0d)", a[7:0], line_no), expected, rsp);
			end
			"R":
			begin
				apb_xfer(a[7:0], 1'b0, '0, rsp);
				expected.prdata = b;
				check_rsp($sformatf("read %02h (line %0d)", a[7:0], line_no), expected, rsp);
			end
			"C":
			begin
				@(negedge SYSCLK);
				check_mask($sformatf("pwr_en_l (line %0d)", line_no), drive_mask_t'(a), pwr_en_l);
			end
			"L":
			begin
				repeat (2) @(posedge SYSCLK);
				@(negedge SYSCLK);
				check_mask($sformatf("health_led (line %0d)", line_no), drive_mask_t'(a),
					health_led);
				check_mask($sformatf("fault_led (line %0d)", line_no), drive_mask_t'(b),
					fault_led);
			end
			"B":
				blink_window($sformatf("blink drive %0d led %0d (line %0d)", a, b, line_no),
					int'(a), int'(b), int'(c));
			default:
			begin
				other_errors++;
				$display("trace line %0d has an unknown operation, %0d fields read", line_no, n);
			end
		endcase
	endtask

	initial
	begin
		int    fd;
		int    line_no;
		int    budget;
		string line;
		void'($urandom(67971));
		RESET_N <= 1'b0;
		apb_req <= '0;
		insert_l <= '1;
		p5v_good <= '0;
		p12v_good <= '0;
		line_no = 0;
		budget = 3 + MARGIN;
		fd = $fopen("bp_trace.txt", "r");
		if (fd == 0)
		begin
			other_errors++;
			$display("could not open the trace file bp_trace.txt");
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				line_no++;
				if (line.len() > 0 && line.getc(0) >= "A" && line.getc(0) <= "Z")
				begin
					trace_lines.push_back(line);
					trace_line_no.push_back(line_no);
					budget += line_budget(line.getc(0));
				end
			end
			$fclose(fd);
		end
		cycle_limit = budget;

		repeat (3) @(posedge SYSCLK);
		RESET_N <= 1'b1;
		foreach (trace_lines[i])
			run_line(trace_lines[i], trace_line_no[i]);
		repeat (2) @(posedge SYSCLK);

		$display("errors: response %0d, mask %0d, blink %0d, other %0d",
			rsp_errors, mask_errors, blink_errors, other_errors);
		if (rsp_errors + mask_errors + blink_errors + other_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bp_trace.txt ====
# All fields hex. P insert_l p5v_good p12v_good | W addr data exp_pslverr | R addr exp_data exp_pslverr
# C exp_pwr_en_l | L exp_health exp_fault | B drive led(0 health 1 fault 2 heartbeat) mode
# State right after reset
C 7fff
L 0000 0000
R 0c 00000000 0
R 10 00000000 0
R 14 00000000 0
# Status pins, insert_l reads back inverted
P 7ff0 000f 0007
R 00 0000000f 0
R 04 0000000f 0
R 08 00000007 0
P 2a55 5500 1234
R 00 000055aa 0
R 04 00005500 0
R 08 00001234 0
R 3c b4150001 0
# Power enable mask
W 0c ffffffff 0
R 0c 00007fff 0
C 0000
W 0c 00012345 0
R 0c 00002345 0
C 5cba
# Steady LED modes
W 10 00000011 0
R 10 00000011 0
W 14 10000004 0
R 14 10000004 0
L 0005 4002
W 10 c0000055 0
R 10 00000055 0
L 000f 4002
# Error responses leave the registers alone
R 20 00000000 1
R 40 00000000 1
R ff 00000000 1
W 3c 12345678 1
W 00 00007fff 1
W 44 0000ffff 1
R 3c b4150001 0
R 00 000055aa 0
R 0c 00002345 0
R 10 00000055 0
C 5cba
# Blink windows
W 10 00000b55 0
R 10 00000b55 0
B 5 0 3
B 6 0 2
B 1 0 1
W 14 2000000c 0
B f 1 2
B 2 1 3
B 0 2 0
# Back to steady and unpowered
W 10 00000000 0
W 14 00000000 0
L 0000 0000
W 0c 00000000 0
C 7fff

// ==== files.f ====
bp_pkg.sv
drive_status_sync.sv
blink_timebase.sv
drive_led_driver.sv
bp_reg_ctrl.sv
bp_top.sv
tb_bp_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the drive backplane testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_bp_top -f files.f \
	&& sim_out="$(./obj_dir/Vtb_bp_top 2>&1)" \
	&& printf '%s\n' "$sim_out" \
	&& printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS' \
	|| { echo "simulation did not pass"; exit 1; }
